//--- Makefile
# Verilator build and run of the TLB testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_tlb
FILELIST  = files.f
BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

SOURCES = $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/tlb_csr_stage.sv
// --------------------------------------------------------------------------
// one register stage on the CSR inputs
// a CSR change is seen by lookups one cycle later
// resets to M mode with paging off, so lookups start in bare mode
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module tlb_csr_stage
  import tlb_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset_n,
  input  tlb_priv_t i_status_prv,
  input  logic      i_satp_mode,
  input  logic      i_sum,
  input  logic      i_mxr,
  output tlb_priv_t o_priv,
  output logic      o_sum,
  output logic      o_mxr,
  output logic      o_vm_enabled
);

  tlb_priv_t r_priv;
  logic      r_satp_mode;
  logic      r_sum;
  logic      r_mxr;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_priv      <= PRIV_M;
      r_satp_mode <= 1'b0;
      r_sum       <= 1'b0;
      r_mxr       <= 1'b0;
    end else begin
      r_priv      <= i_status_prv;
      r_satp_mode <= i_satp_mode;
      r_sum       <= i_sum;
      r_mxr       <= i_mxr;
    end
  end

  assign o_priv = r_priv;
  assign o_sum  = r_sum;
  assign o_mxr  = r_mxr;

  // M mode always translates bare
  assign o_vm_enabled = r_satp_mode & ((r_priv == PRIV_U) | (r_priv == PRIV_S));

endmodule

//--- design/tlb_entry_array.sv
// --------------------------------------------------------------------------
// fully associative entry storage with same-cycle lookup
// assumes at most one entry hits; overlapping mappings are not detected
// flush wins over a refill write in the same cycle
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "tlb_params.svh"

module tlb_entry_array
  import tlb_pkg::*;
(
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic [`TLB_VADDR_W-1:0] i_vaddr,
  input  logic                    i_vm_enabled,
  input  logic                    i_flush,
  input  logic                    i_wr_en,
  input  logic [`TLB_VPN_W-1:0]   i_wr_vpn,
  input  tlb_pte_t                i_wr_pte,
  input  logic                    i_wr_level,
  output logic                    o_hit,
  output tlb_entry_t              o_hit_entry,
  output logic [`TLB_PADDR_W-1:0] o_paddr
);

  tlb_entry_t              r_entries [`TLB_ENTRIES];
  logic [`TLB_VPN_W-1:0]   w_vpn;
  logic [`TLB_ENTRIES-1:0] w_hit_vec;
  logic [`TLB_PPN_W-1:0]   w_sel_ppn;
  logic [`TLB_IDX_W-1:0]   w_repl_idx;
  logic                    w_leaf;
  tlb_entry_t              w_new_entry;

  assign w_vpn = i_vaddr[`TLB_VADDR_W-1:`TLB_PG_IDX_W];

  // --------------------------------------------------------------------------
  // lookup
  // --------------------------------------------------------------------------
  // superpage entries ignore the low index field
  always_comb begin
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      w_hit_vec[i] = i_vm_enabled & r_entries[i].valid &
                     (r_entries[i].tag[`TLB_VPN_W-1:`TLB_VPN_FIELD_W] ==
                      w_vpn[`TLB_VPN_W-1:`TLB_VPN_FIELD_W]) &
                     (r_entries[i].level |
                      (r_entries[i].tag[`TLB_VPN_FIELD_W-1:0] ==
                       w_vpn[`TLB_VPN_FIELD_W-1:0]));
    end
  end

  // and-or mux over the one-hot hit vector
  always_comb begin
    o_hit_entry = '0;
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      if (w_hit_vec[i]) begin
        o_hit_entry = o_hit_entry | r_entries[i];
      end
    end
  end

  assign o_hit = |w_hit_vec;

  // superpage takes the low PPN field from the VPN
  assign w_sel_ppn = {o_hit_entry.ppn[`TLB_PPN_W-1:`TLB_VPN_FIELD_W],
                      o_hit_entry.level ? w_vpn[`TLB_VPN_FIELD_W-1:0] :
                                          o_hit_entry.ppn[`TLB_VPN_FIELD_W-1:0]};

  assign o_paddr = i_vm_enabled ? {w_sel_ppn, i_vaddr[`TLB_PG_IDX_W-1:0]} :
                   {{(`TLB_PADDR_W - `TLB_VADDR_W){1'b0}}, i_vaddr};

  // --------------------------------------------------------------------------
  // refill
  // --------------------------------------------------------------------------
  // lowest free slot, entry 0 when full
  always_comb begin
    w_repl_idx = '0;
    for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
      if (!r_entries[i].valid) begin
        w_repl_idx = i[`TLB_IDX_W-1:0];
      end
    end
  end

  // non-leaf or invalid PTE is stored with no rights, so the retry faults
  assign w_leaf = i_wr_pte.v & i_wr_pte.a & (i_wr_pte.r | i_wr_pte.x);

  always_comb begin
    w_new_entry.valid = 1'b1;
    w_new_entry.level = i_wr_level;
    w_new_entry.tag   = i_wr_vpn;
    w_new_entry.ppn   = i_wr_pte.ppn;
    w_new_entry.u     = i_wr_pte.u;
    w_new_entry.sr    = w_leaf & i_wr_pte.r;
    w_new_entry.sw    = w_leaf & i_wr_pte.w & i_wr_pte.d;
    w_new_entry.sx    = w_leaf & i_wr_pte.x;
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < `TLB_ENTRIES; i++) begin
        r_entries[i].valid <= 1'b0;
      end
    end else if (i_flush) begin
      for (int i = 0; i < `TLB_ENTRIES; i++) begin
        r_entries[i].valid <= 1'b0;
      end
    end else if (i_wr_en) begin
      r_entries[w_repl_idx] <= w_new_entry;
    end
  end

endmodule

//--- design/tlb_perm_check.sv
// --------------------------------------------------------------------------
// page fault decision for the entry that hits
// no faults are raised on a miss or in bare mode (no hit then)
// M-mode accesses never reach here with a hit
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module tlb_perm_check
  import tlb_pkg::*;
(
  input  logic       i_hit,
  input  tlb_entry_t i_entry,
  input  tlb_cmd_t   i_cmd,
  input  tlb_priv_t  i_priv,
  input  logic       i_sum,
  input  logic       i_mxr,
  output tlb_fault_t o_fault
);

  logic w_priv_s;
  logic w_rw_ok;
  logic w_x_ok;
  logic w_ld_ok;
  logic w_st_ok;
  logic w_inst_ok;

  assign w_priv_s = (i_priv == PRIV_S);

  // supervisor touches user pages for data only with SUM
  assign w_rw_ok = w_priv_s ? (~i_entry.u | i_sum) : i_entry.u;

  // supervisor never executes from user pages
  assign w_x_ok = w_priv_s ? ~i_entry.u : i_entry.u;

  // MXR lets loads read execute-only pages
  assign w_ld_ok   = w_rw_ok & (i_entry.sr | (i_mxr & i_entry.sx));
  assign w_st_ok   = w_rw_ok & i_entry.sw;
  assign w_inst_ok = w_x_ok & i_entry.sx;

  // --------------------------------------------------------------------------
  // per-command faults
  // --------------------------------------------------------------------------
  always_comb begin
    o_fault.ld   = 1'b0;
    o_fault.st   = 1'b0;
    o_fault.inst = 1'b0;
    if (i_hit) begin
      case (i_cmd)
        CMD_READ: begin
          o_fault.ld = ~w_ld_ok;
        end
        CMD_WRITE: begin
          o_fault.st = ~w_st_ok;
        end
        CMD_EXEC: begin
          o_fault.inst = ~w_inst_ok;
        end
        default: begin
          o_fault = '0;
        end
      endcase
    end
  end

endmodule

//--- design/tlb_pkg.sv
// --------------------------------------------------------------------------
// types shared by the TLB blocks
// the PTE follows the leaf layout returned by the walker, without RSW bits
// --------------------------------------------------------------------------
`include "tlb_params.svh"

package tlb_pkg;

  typedef enum logic [1:0] {
    CMD_READ  = 2'd0,
    CMD_WRITE = 2'd1,
    CMD_EXEC  = 2'd2
  } tlb_cmd_t;

  // encodings as in the privileged spec
  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } tlb_priv_t;

  typedef struct packed {
    logic [`TLB_PPN_W-1:0] ppn;
    logic                  d;
    logic                  a;
    logic                  g;
    logic                  u;
    logic                  x;
    logic                  w;
    logic                  r;
    logic                  v;
  } tlb_pte_t;

  // sr/sw/sx already masked by the leaf and dirty rules
  typedef struct packed {
    logic                  valid;
    logic                  level;
    logic [`TLB_VPN_W-1:0] tag;
    logic [`TLB_PPN_W-1:0] ppn;
    logic                  u;
    logic                  sr;
    logic                  sw;
    logic                  sx;
  } tlb_entry_t;

  typedef struct packed {
    logic ld;
    logic st;
    logic inst;
  } tlb_fault_t;

  typedef enum logic [1:0] {
    ST_READY           = 2'd0,
    ST_REQUEST         = 2'd1,
    ST_WAIT            = 2'd2,
    ST_WAIT_INVALIDATE = 2'd3
  } tlb_state_t;

endpackage

//--- design/tlb_refill_ctrl.sv
// --------------------------------------------------------------------------
// miss detection and refill FSM with a four-phase req/ack walker link
// only one refill is outstanding; requests are refused until it ends
// an sfence during a refill lets the handshake finish without a write
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "tlb_params.svh"

module tlb_refill_ctrl
  import tlb_pkg::*;
(
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic                    i_req_valid,
  input  logic [`TLB_VADDR_W-1:0] i_req_vaddr,
  input  logic                    i_vm_enabled,
  input  logic                    i_hit,
  input  logic                    i_sfence,
  input  logic                    i_ptw_ack,
  output logic                    o_req_ready,
  output logic                    o_miss,
  output logic                    o_ptw_req,
  output logic [`TLB_VPN_W-1:0]   o_ptw_vpn,
  output logic                    o_wr_en,
  output logic                    o_tlb_update
);

  tlb_state_t            r_state;
  tlb_state_t            r_state_dly;
  logic                  r_ack_seen;
  logic [`TLB_VPN_W-1:0] r_vpn;
  logic                  w_accept_miss;

  assign o_req_ready   = (r_state == ST_READY);
  assign o_miss        = i_req_valid & i_vm_enabled & ~i_hit;
  assign w_accept_miss = o_miss & o_req_ready;

  // req drops once ack has been seen, then wait for ack to fall
  assign o_ptw_req = (r_state != ST_READY) & ~r_ack_seen;
  assign o_ptw_vpn = r_vpn;
  assign o_wr_en   = o_ptw_req & i_ptw_ack & (r_state != ST_WAIT_INVALIDATE);

  assign o_tlb_update = (r_state == ST_READY) & (r_state_dly != ST_READY);

  always_ff @(posedge i_clk) begin
    if (w_accept_miss) begin
      r_vpn <= i_req_vaddr[`TLB_VADDR_W-1:`TLB_PG_IDX_W];
    end
  end

  // --------------------------------------------------------------------------
  // refill FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state     <= ST_READY;
      r_state_dly <= ST_READY;
      r_ack_seen  <= 1'b0;
    end else begin
      r_state_dly <= r_state;
      case (r_state)
        ST_READY: begin
          if (w_accept_miss) begin
            r_state <= ST_REQUEST;
          end
        end
        // request, wait and invalidated wait share the handshake
        default: begin
          if (r_ack_seen & ~i_ptw_ack) begin
            r_state    <= ST_READY;
            r_ack_seen <= 1'b0;
          end else begin
            if (i_ptw_ack) begin
              r_ack_seen <= 1'b1;
            end
            if (i_sfence) begin
              r_state <= ST_WAIT_INVALIDATE;
            end else if (r_state == ST_REQUEST) begin
              r_state <= ST_WAIT;
            end
          end
        end
      endcase
    end
  end

endmodule

//--- design/tlb_top.sv
// --------------------------------------------------------------------------
// TLB top level, lookup is combinational in the request cycle
// results are only meaningful while o_req_ready is high
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "tlb_params.svh"

module tlb_top
  import tlb_pkg::*;
(
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic                    i_sfence,
  input  logic                    i_req_valid,
  input  logic [`TLB_VADDR_W-1:0] i_req_vaddr,
  input  tlb_cmd_t                i_req_cmd,
  input  tlb_priv_t               i_status_prv,
  input  logic                    i_satp_mode,
  input  logic                    i_sum,
  input  logic                    i_mxr,
  input  logic                    i_ptw_ack,
  input  tlb_pte_t                i_ptw_pte,
  input  logic                    i_ptw_level,
  output logic                    o_req_ready,
  output logic                    o_resp_miss,
  output logic [`TLB_PADDR_W-1:0] o_resp_paddr,
  output tlb_fault_t              o_resp_fault,
  output logic                    o_ptw_req,
  output logic [`TLB_VPN_W-1:0]   o_ptw_vpn,
  output logic                    o_tlb_update
);

  tlb_priv_t  w_priv;
  logic       w_sum;
  logic       w_mxr;
  logic       w_vm_enabled;
  logic       w_hit;
  tlb_entry_t w_hit_entry;
  logic       w_wr_en;

  tlb_csr_stage u_csr_stage (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_status_prv (i_status_prv),
    .i_satp_mode  (i_satp_mode),
    .i_sum        (i_sum),
    .i_mxr        (i_mxr),
    .o_priv       (w_priv),
    .o_sum        (w_sum),
    .o_mxr        (w_mxr),
    .o_vm_enabled (w_vm_enabled)
  );

  // refill writes the VPN latched at the miss
  tlb_entry_array u_entry_array (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_vaddr      (i_req_vaddr),
    .i_vm_enabled (w_vm_enabled),
    .i_flush      (i_sfence),
    .i_wr_en      (w_wr_en),
    .i_wr_vpn     (o_ptw_vpn),
    .i_wr_pte     (i_ptw_pte),
    .i_wr_level   (i_ptw_level),
    .o_hit        (w_hit),
    .o_hit_entry  (w_hit_entry),
    .o_paddr      (o_resp_paddr)
  );

  tlb_perm_check u_perm_check (
    .i_hit   (w_hit),
    .i_entry (w_hit_entry),
    .i_cmd   (i_req_cmd),
    .i_priv  (w_priv),
    .i_sum   (w_sum),
    .i_mxr   (w_mxr),
    .o_fault (o_resp_fault)
  );

  tlb_refill_ctrl u_refill_ctrl (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_req_valid  (i_req_valid),
    .i_req_vaddr  (i_req_vaddr),
    .i_vm_enabled (w_vm_enabled),
    .i_hit        (w_hit),
    .i_sfence     (i_sfence),
    .i_ptw_ack    (i_ptw_ack),
    .o_req_ready  (o_req_ready),
    .o_miss       (o_resp_miss),
    .o_ptw_req    (o_ptw_req),
    .o_ptw_vpn    (o_ptw_vpn),
    .o_wr_en      (w_wr_en),
    .o_tlb_update (o_tlb_update)
  );

endmodule

//--- files.f
+incdir+include
design/tlb_pkg.sv
design/tlb_csr_stage.sv
design/tlb_entry_array.sv
design/tlb_perm_check.sv
design/tlb_refill_ctrl.sv
design/tlb_top.sv
test/tlb_chk.sv
test/tb_tlb.sv

//--- include/tlb_params.svh
// --------------------------------------------------------------------------
// geometry of the two-level paged TLB
// 32-bit virtual and 34-bit physical addresses, 4 KiB pages
// a superpage covers one upper index field (4 MiB)
// --------------------------------------------------------------------------
`ifndef TLB_PARAMS_SVH
`define TLB_PARAMS_SVH

// address widths
`define TLB_VADDR_W      32
`define TLB_PADDR_W      34

// page geometry
`define TLB_PG_IDX_W     12
`define TLB_VPN_FIELD_W  10
`define TLB_VPN_W        (`TLB_VADDR_W - `TLB_PG_IDX_W)
`define TLB_PPN_W        (`TLB_PADDR_W - `TLB_PG_IDX_W)

// entry storage
`define TLB_ENTRIES      8
// must cover TLB_ENTRIES
`define TLB_IDX_W        3

`endif

//--- test/tb_tlb.sv
// --------------------------------------------------------------------------
// TLB testbench replaying test/tlb_patterns.hex from the project root
// walker model answers from the map records
// unmapped VPNs get a PTE with v clear
// a miss is retried after the update pulse
// expected values describe the access after any refill
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "tlb_params.svh"

module tb_tlb
  import tlb_pkg::*;
();

  logic                    i_clk;
  logic                    i_reset_n;
  logic                    i_sfence;
  logic                    i_req_valid;
  logic [`TLB_VADDR_W-1:0] i_req_vaddr;
  tlb_cmd_t                i_req_cmd;
  tlb_priv_t               i_status_prv;
  logic                    i_satp_mode;
  logic                    i_sum;
  logic                    i_mxr;
  logic                    i_ptw_ack;
  tlb_pte_t                i_ptw_pte;
  logic                    i_ptw_level;
  logic                    o_req_ready;
  logic                    o_resp_miss;
  logic [`TLB_PADDR_W-1:0] o_resp_paddr;
  tlb_fault_t              o_resp_fault;
  logic                    o_ptw_req;
  logic [`TLB_VPN_W-1:0]   o_ptw_vpn;
  logic                    o_tlb_update;

  logic [87:0]           pat_mem [0:63];
  logic [`TLB_VPN_W-1:0] map_vpn [0:15];
  tlb_pte_t              map_pte [0:15];
  logic                  map_level [0:15];
  int                    map_count;
  int                    acc_q [$];
  int                    num_records;
  int                    timeout_limit = 0;
  int                    cycle_cnt = 0;
  logic [31:0]           rng_state = 32'd98;
  logic [`TLB_VPN_W-1:0] walk_vpn;
  logic                  run_done = 1'b0;
  int                    err_paddr = 0;
  int                    err_fault = 0;
  int                    err_miss = 0;
  int                    err_vpn = 0;
  int                    err_req = 0;
  int                    err_other = 0;

  tlb_top DUT (.*);

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // superpage maps match on the upper index field
  task automatic walk_lookup(input logic [`TLB_VPN_W-1:0] vpn, output tlb_pte_t pte,
                             output logic level);
    pte   = '0;
    level = 1'b0;
    for (int i = 0; i < map_count; i++) begin
      if (map_level[i] ? (map_vpn[i][19:10] == vpn[19:10]) : (map_vpn[i] == vpn)) begin
        pte   = map_pte[i];
        level = map_level[i];
      end
    end
  endtask

  task automatic check_paddr(input int n, input logic [`TLB_PADDR_W-1:0] got,
                             input logic [`TLB_PADDR_W-1:0] exp);
    if (got !== exp) begin
      err_paddr++;
      $display("ERR o_resp_paddr record %0d: got %h expected %h", n, got, exp);
    end
  endtask

  task automatic check_fault(input int n, input tlb_fault_t got, input tlb_fault_t exp);
    if (got !== exp) begin
      err_fault++;
      $display("ERR o_resp_fault record %0d: got %h expected %h", n, got, exp);
    end
  endtask

  task automatic check_miss(input int n, input logic got, input logic exp);
    if (got !== exp) begin
      err_miss++;
      $display("ERR o_resp_miss record %0d: got %h expected %h", n, got, exp);
    end
  endtask

  task automatic check_vpn(input int n, input logic [`TLB_VPN_W-1:0] got,
                           input logic [`TLB_VPN_W-1:0] exp);
    if (got !== exp) begin
      err_vpn++;
      $display("ERR o_ptw_vpn record %0d: got %h expected %h", n, got, exp);
    end
  endtask

  task automatic check_ptw_req(input int n, input logic got, input logic exp);
    if (got !== exp) begin
      err_req++;
      $display("ERR o_ptw_req record %0d: got %h expected %h", n, got, exp);
    end
  endtask

  // called on a falling edge and returns after the accepting rising edge
  task automatic present_request(input logic [31:0] vaddr, input tlb_cmd_t cmd,
                                 output logic miss, output logic [`TLB_PADDR_W-1:0] paddr,
                                 output tlb_fault_t fault);
    i_req_valid = 1'b1;
    i_req_vaddr = vaddr;
    i_req_cmd   = cmd;
    #5;
    if (o_req_ready !== 1'b1) begin
      err_other++;
      $display("request presented while the TLB was not ready");
    end
    miss  = o_resp_miss;
    paddr = o_resp_paddr;
    fault = o_resp_fault;
    @(posedge i_clk);
  endtask

  // walker request is up one edge after the accepted miss
  task automatic finish_refill(input int n, input logic inv);
    @(negedge i_clk);
    i_req_valid = 1'b0;
    check_ptw_req(n, o_ptw_req, 1'b1);
    if (inv) begin
      i_sfence = 1'b1;
      @(negedge i_clk);
      i_sfence = 1'b0;
    end
    while (!o_tlb_update) @(negedge i_clk);
  endtask

  task automatic run_access(input int n);
    logic [87:0]             rec;
    logic [31:0]             vaddr;
    tlb_cmd_t                cmd;
    logic                    inv;
    logic                    got_miss;
    logic [`TLB_PADDR_W-1:0] got_paddr;
    tlb_fault_t              got_fault;
    rec   = pat_mem[n];
    vaddr = rec[83:52];
    cmd   = tlb_cmd_t'(rec[49:48]);
    inv   = rec[50];
    @(negedge i_clk);
    i_status_prv = tlb_priv_t'(rec[45:44]);
    i_satp_mode  = rec[43];
    i_sum        = rec[42];
    i_mxr        = rec[41];
    i_sfence     = rec[40];
    // CSR stage needs one edge
    @(negedge i_clk);
    i_sfence = 1'b0;
    present_request(vaddr, cmd, got_miss, got_paddr, got_fault);
    check_miss(n, got_miss, rec[3]);
    if (got_miss) begin
      finish_refill(n, inv);
      check_vpn(n, walk_vpn, vaddr[31:12]);
      if (inv) begin
        // invalidated refill leaves the page absent
        present_request(vaddr, cmd, got_miss, got_paddr, got_fault);
        check_miss(n, got_miss, 1'b1);
        finish_refill(n, 1'b0);
      end
      present_request(vaddr, cmd, got_miss, got_paddr, got_fault);
      check_miss(n, got_miss, 1'b0);
    end
    check_paddr(n, got_paddr, rec[37:4]);
    check_fault(n, got_fault, tlb_fault_t'(rec[2:0]));
    @(negedge i_clk);
    i_req_valid = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // walker model with a random ack delay of 1 to 5 cycles
  // --------------------------------------------------------------------------
  initial begin : walker_model
    int       delay;
    tlb_pte_t pte;
    logic     lvl;
    i_ptw_ack   = 1'b0;
    i_ptw_pte   = '0;
    i_ptw_level = 1'b0;
    forever begin
      @(negedge i_clk);
      if (o_ptw_req && i_reset_n) begin
        rng_state = xorshift32(rng_state);
        delay     = int'(rng_state % 32'd5) + 1;
        repeat (delay) @(negedge i_clk);
        walk_lookup(o_ptw_vpn, pte, lvl);
        walk_vpn    = o_ptw_vpn;
        i_ptw_pte   = pte;
        i_ptw_level = lvl;
        i_ptw_ack   = 1'b1;
        while (o_ptw_req) @(negedge i_clk);
        i_ptw_ack = 1'b0;
      end
    end
  end

  initial begin : watchdog
    do begin
      @(posedge i_clk);
      cycle_cnt = cycle_cnt + 1;
    end while (timeout_limit == 0 || cycle_cnt <= timeout_limit);
    $display("timeout after %0d cycles, the pattern replay did not finish", cycle_cnt);
    run_done = 1'b1;
    $display("Simulation failed");
    $finish;
  end

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial begin : main_seq
    logic [3:0] kind;
    i_reset_n    = 1'b0;
    i_sfence     = 1'b0;
    i_req_valid  = 1'b0;
    i_req_vaddr  = '0;
    i_req_cmd    = CMD_READ;
    i_status_prv = PRIV_M;
    i_satp_mode  = 1'b0;
    i_sum        = 1'b0;
    i_mxr        = 1'b0;
    map_count    = 0;
    num_records  = 0;
    for (int i = 0; i < 64; i++) begin
      pat_mem[i] = '0;
    end
    $readmemh("test/tlb_patterns.hex", pat_mem);
    for (int i = 0; i < 64; i++) begin
      kind = pat_mem[i][87:84];
      if (kind == 4'd0) begin
        break;
      end
      num_records++;
      if (kind == 4'd1) begin
        map_vpn[map_count]   = pat_mem[i][83:64];
        map_pte[map_count]   = tlb_pte_t'(pat_mem[i][61:32]);
        map_level[map_count] = pat_mem[i][28];
        map_count++;
      end else begin
        acc_q.push_back(i);
      end
    end
    if (acc_q.size() == 0) begin
      err_other++;
      $display("no access records were loaded from the pattern file");
    end
    timeout_limit = num_records * 40;
    repeat (10) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;
    for (int k = 0; k < acc_q.size(); k++) begin
      run_access(acc_q[k]);
    end
    repeat (2) @(negedge i_clk);
    $display("errors: paddr=%0d fault=%0d miss=%0d vpn=%0d req=%0d other=%0d",
             err_paddr, err_fault, err_miss, err_vpn, err_req, err_other);
    run_done = 1'b1;
    if (err_paddr + err_fault + err_miss + err_vpn + err_req + err_other == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // run ended before the summary
  final begin
    if (!run_done) begin
      $display("Simulation failed");
    end
  end

endmodule

//--- test/tlb_chk.sv
// --------------------------------------------------------------------------
// concurrent checks on the walker handshake and the ready rule
// bound into tlb_top and disabled while reset is low
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "tlb_params.svh"

module tlb_chk (
  input logic                  i_clk,
  input logic                  i_reset_n,
  input logic                  i_ptw_ack,
  input logic                  i_ptw_req,
  input logic [`TLB_VPN_W-1:0] i_ptw_vpn,
  input logic                  i_tlb_update,
  input logic                  i_req_ready
);

  // a new walker request waits for ack to fall
  a_req_rise_ack_low : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $rose(i_ptw_req) |-> !i_ptw_ack)
    else $error("walker request raised while ack still high");

  a_vpn_stable : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_ptw_req && $past(i_ptw_req)) |-> $stable(i_ptw_vpn))
    else $error("walker VPN changed during a request");

  a_update_pulse : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_tlb_update |=> !i_tlb_update)
    else $error("update pulse longer than one cycle");

  // ready only returns once the walker has released ack
  a_busy_not_ready : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_ptw_req || i_ptw_ack) |-> !i_req_ready)
    else $error("ready high during a refill");

endmodule

bind tlb_top tlb_chk u_chk (
  .i_clk        (i_clk),
  .i_reset_n    (i_reset_n),
  .i_ptw_ack    (i_ptw_ack),
  .i_ptw_req    (o_ptw_req),
  .i_ptw_vpn    (o_ptw_vpn),
  .i_tlb_update (o_tlb_update),
  .i_req_ready  (o_req_ready)
);

//--- test/tlb_patterns.hex
// type 1 map: type_vpn_pte(32b)_level_pad   type 2 access: type_vaddr_cmd(bit2 sfence in refill)
// _priv_flags(mode,sum,mxr,sfence before)_paddr(36b)_exp(bit3 first miss, bits2:0 ld,st,inst)
1_10000_012345C7_0_0000000
1_40000_0EAC005B_1_0000000
1_20000_00077759_0_0000000
1_30000_00055547_0_0000000
2_12345678_0_3_8_012345678_0
2_FFFFF004_2_1_0_0FFFFF004_0
2_10000ABC_0_1_8_012345ABC_8
2_10000010_1_1_8_012345010_0
2_10000020_0_0_8_012345020_4
2_40123456_0_0_8_0EAD23456_8
2_403FF000_2_0_8_0EAFFF000_0
2_40000008_0_1_8_0EAC00008_4
2_40000008_0_1_C_0EAC00008_0
2_40000008_2_1_C_0EAC00008_1
2_20000100_0_0_8_000777100_C
2_20000100_0_0_A_000777100_0
2_30000044_1_1_8_000555044_A
2_50000000_0_1_8_000000000_C
2_10000ABC_0_1_9_012345ABC_8
2_30000044_4_1_8_000555044_8
2_60000000_0_1_9_000000000_C
2_60001000_0_1_8_000000000_C
2_60002000_0_1_8_000000000_C
2_60003000_0_1_8_000000000_C
2_60004000_0_1_8_000000000_C
2_60005000_0_1_8_000000000_C
2_60006000_0_1_8_000000000_C
2_60007000_0_1_8_000000000_C
2_60008000_0_1_8_000000000_C
2_60000000_0_1_8_000000000_C
2_60007000_0_1_8_000000000_4
2_60003000_0_1_8_000000000_4
0_00000000_0_0_0_000000000_0
